// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the core with its testbench in Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpu_tb -f sim.f \
	--Mdir obj_dir -o cpu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim.f ====
+incdir+src
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/forward_unit.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu5stage.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

// ==== src/cpu5stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module cpu5stage (
	input logic input_clk,
	input logic rst,
	input logic imem_we,
	input logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr,
	input logic [`XLEN-1:0] imem_wdata,
	output logic [`XLEN-1:0] PC,
	output logic [`XLEN-1:0] cycles_consumed,
	output logic retire_valid,
	output cpu_pkg::retire_t retire,
	output logic halted
);
	import cpu_pkg::*;

	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	fwd_sel_t fwd_store;
	logic stall;
	logic redirect;
	logic [`XLEN-1:0] redirect_pc;
	logic [`XLEN-1:0] mem_fwd;

	fetch_stage i_fetch (
		.input_clk(input_clk),
		.rst(rst),
		.stall(stall),
		.redirect(redirect),
		.halted(halted),
		.redirect_pc(redirect_pc),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.pc(PC),
		.if_id(if_id)
	);

	decode_stage i_decode (
		.input_clk(input_clk),
		.rst(rst),
		.redirect(redirect),
		.halted(halted),
		.if_id(if_id),
		.wb(mem_wb),
		.stall(stall),
		.id_ex(id_ex)
	);

	forward_unit i_forward (
		.id_ex(id_ex),
		.ex_mem(ex_mem),
		.mem_wb(mem_wb),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.fwd_store(fwd_store)
	);

	execute_stage i_execute (
		.input_clk(input_clk),
		.rst(rst),
		.halted(halted),
		.id_ex(id_ex),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.fwd_store(fwd_store),
		.mem_fwd(mem_fwd),
		.wb_fwd(mem_wb.wdata),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_mem(ex_mem)
	);

	memory_stage i_memory (
		.input_clk(input_clk),
		.rst(rst),
		.ex_mem(ex_mem),
		.mem_fwd(mem_fwd),
		.mem_wb(mem_wb),
		.halted(halted)
	);

	// One strobe per architectural register write
	assign retire_valid = mem_wb.valid && mem_wb.regwrite && (mem_wb.rd != '0);
	assign retire = '{rd: mem_wb.rd, wdata: mem_wb.wdata};

	always_ff @(posedge input_clk) begin
		if (rst)
			cycles_consumed <= '0;
		else if (!halted)
			cycles_consumed <= cycles_consumed + 1;
	end

endmodule

`default_nettype wire

// ==== src/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Width of a machine word, also the width of the PC
`define XLEN 32

// Architectural registers, r0 always reads as zero
`define NREGS 32

// Both memories are word addressed
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`endif

// ==== src/cpu_pkg.sv ====
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

	// Encodings of instruction bits 31..26
	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_XOR  = 6'd5,
		OP_SLT  = 6'd6,
		OP_ADDI = 6'd7,
		OP_LW   = 6'd8,
		OP_SW   = 6'd9,
		OP_BEQ  = 6'd10,
		OP_BNE  = 6'd11,
		OP_JAL  = 6'd12,
		OP_HLT  = 6'd13
	} opcode_t;

	typedef enum logic [1:0] {
		FWD_REG = 2'd0, // Value read in decode
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] inst;
	} if_id_t;

	typedef struct packed {
		logic valid;
		opcode_t op;
		logic [$clog2(`NREGS)-1:0] rd;
		logic [$clog2(`NREGS)-1:0] rs1;
		logic [$clog2(`NREGS)-1:0] rs2;
		logic [`XLEN-1:0] rs1_val;
		logic [`XLEN-1:0] rs2_val;
		logic [`XLEN-1:0] imm;
		logic [`XLEN-1:0] pc;
		logic regwrite;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		opcode_t op;
		logic [$clog2(`NREGS)-1:0] rd;
		logic [`XLEN-1:0] alu_out; // Also the load or store address
		logic [`XLEN-1:0] store_data;
		logic regwrite;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		opcode_t op;
		logic [$clog2(`NREGS)-1:0] rd;
		logic [`XLEN-1:0] wdata;
		logic regwrite;
	} mem_wb_t;

	typedef struct packed {
		logic [$clog2(`NREGS)-1:0] rd;
		logic [`XLEN-1:0] wdata;
	} retire_t;

endpackage

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module decode_stage (
	input logic input_clk,
	input logic rst,
	input logic redirect,
	input logic halted,
	input cpu_pkg::if_id_t if_id,
	input cpu_pkg::mem_wb_t wb,
	output logic stall,
	output cpu_pkg::id_ex_t id_ex
);
	import cpu_pkg::*;

	localparam int RW = $clog2(`NREGS);

	logic [`XLEN-1:0] regs [`NREGS];
	opcode_t op;
	logic [RW-1:0] rd;
	logic [RW-1:0] rs1;
	logic [RW-1:0] rs2;
	logic uses_rs1;
	logic uses_rs2;
	logic writes_rd;
	logic wb_we;
	id_ex_t id_ex_d;

	// Encodings past OP_HLT decode as a NOP
	assign op = (if_id.inst[31:26] <= OP_HLT) ? opcode_t'(if_id.inst[31:26]) : OP_NOP;
	assign rd = if_id.inst[25:21];
	assign rs1 = if_id.inst[20:16];
	assign rs2 = if_id.inst[15:11];

	always_comb begin
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		writes_rd = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				writes_rd = 1'b1;
			end
			OP_ADDI, OP_LW: begin
				uses_rs1 = 1'b1; // The rs2 field overlaps the immediate here
				writes_rd = 1'b1;
			end
			OP_SW, OP_BEQ, OP_BNE: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			OP_JAL: writes_rd = 1'b1;
			default: ;
		endcase
	end

	assign wb_we = wb.valid && wb.regwrite && (wb.rd != '0);

	// Writeback in the same cycle is seen by the read
	function automatic logic [`XLEN-1:0] read_reg(input logic [RW-1:0] idx);
		if (idx == '0)
			return '0;
		if (wb_we && (wb.rd == idx))
			return wb.wdata;
		return regs[idx];
	endfunction

	// A load result only exists after MEM, so its consumer waits one cycle
	assign stall = if_id.valid && id_ex.valid && (id_ex.op == OP_LW) && (id_ex.rd != '0) &&
		((uses_rs1 && (rs1 == id_ex.rd)) || (uses_rs2 && (rs2 == id_ex.rd)));

	always_comb begin
		id_ex_d.valid = if_id.valid && !stall && !redirect;
		id_ex_d.op = op;
		id_ex_d.rd = rd;
		id_ex_d.rs1 = rs1;
		id_ex_d.rs2 = rs2;
		id_ex_d.rs1_val = read_reg(rs1);
		id_ex_d.rs2_val = read_reg(rs2);
		id_ex_d.imm = {{(`XLEN-16){if_id.inst[15]}}, if_id.inst[15:0]};
		id_ex_d.pc = if_id.pc;
		id_ex_d.regwrite = id_ex_d.valid && writes_rd;
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			for (int i = 0; i < `NREGS; i++)
				regs[i] <= '0;
		end else if (wb_we) begin
			regs[wb.rd] <= wb.wdata;
		end
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
			id_ex.regwrite <= 1'b0;
		end else if (!halted) begin
			id_ex <= id_ex_d; // Stall and redirect both leave a bubble
		end
	end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module execute_stage (
	input logic input_clk,
	input logic rst,
	input logic halted,
	input cpu_pkg::id_ex_t id_ex,
	input cpu_pkg::fwd_sel_t fwd_a,
	input cpu_pkg::fwd_sel_t fwd_b,
	input cpu_pkg::fwd_sel_t fwd_store,
	input logic [`XLEN-1:0] mem_fwd,
	input logic [`XLEN-1:0] wb_fwd,
	output logic redirect,
	output logic [`XLEN-1:0] redirect_pc,
	output cpu_pkg::ex_mem_t ex_mem
);
	import cpu_pkg::*;

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] rs2_fwd;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] store_data;
	logic [`XLEN-1:0] alu_out;
	logic [`XLEN-1:0] pc_next;
	logic taken;
	logic hlt_ahead;

	function automatic logic [`XLEN-1:0] sel_src(input fwd_sel_t sel,
		input logic [`XLEN-1:0] reg_val);
		case (sel)
			FWD_MEM: return mem_fwd;
			FWD_WB: return wb_fwd;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = sel_src(fwd_a, id_ex.rs1_val);
	assign rs2_fwd = sel_src(fwd_b, id_ex.rs2_val);
	assign store_data = sel_src(fwd_store, id_ex.rs2_val);
	assign op_b = (id_ex.op inside {OP_ADDI, OP_LW, OP_SW}) ? id_ex.imm : rs2_fwd;
	assign pc_next = id_ex.pc + 1;

	always_comb begin
		case (id_ex.op)
			OP_ADD, OP_ADDI, OP_LW, OP_SW: alu_out = op_a + op_b;
			OP_SUB: alu_out = op_a - op_b;
			OP_AND: alu_out = op_a & op_b;
			OP_OR: alu_out = op_a | op_b;
			OP_XOR: alu_out = op_a ^ op_b;
			OP_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			OP_JAL: alu_out = pc_next; // Link value
			default: alu_out = '0;
		endcase
	end

	always_comb begin
		case (id_ex.op)
			OP_BEQ: taken = (op_a == op_b);
			OP_BNE: taken = (op_a != op_b);
			OP_JAL: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// An instruction behind a halt must not move the PC the halt freezes
	assign hlt_ahead = ex_mem.valid && (ex_mem.op == OP_HLT);
	assign redirect = id_ex.valid && taken && !hlt_ahead;
	assign redirect_pc = pc_next + id_ex.imm;

	always_ff @(posedge input_clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
			ex_mem.regwrite <= 1'b0;
		end else if (!halted) begin
			ex_mem <= '{
				valid: id_ex.valid,
				op: id_ex.op,
				rd: id_ex.rd,
				alu_out: alu_out,
				store_data: store_data,
				regwrite: id_ex.valid && id_ex.regwrite
			};
		end
	end

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module fetch_stage (
	input logic input_clk,
	input logic rst,
	input logic stall,
	input logic redirect,
	input logic halted,
	input logic [`XLEN-1:0] redirect_pc,
	input logic imem_we,
	input logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr,
	input logic [`XLEN-1:0] imem_wdata,
	output logic [`XLEN-1:0] pc,
	output cpu_pkg::if_id_t if_id
);
	localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

	logic [`XLEN-1:0] imem [`IMEM_DEPTH];
	logic [`XLEN-1:0] inst;

	assign inst = imem[pc[IMEM_AW-1:0]]; // Asynchronous read, the PC wraps over the depth

	// Programs are only loaded while the core is held in reset
	always_ff @(posedge input_clk) begin
		if (rst && imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			pc <= '0;
			if_id.valid <= 1'b0;
		end else if (!halted) begin
			if (redirect) begin
				pc <= redirect_pc;
				if_id.valid <= 1'b0; // Word after the branch is on the wrong path
			end else if (!stall) begin
				pc <= pc + 1;
				if_id.valid <= 1'b1;
				if_id.pc <= pc;
				if_id.inst <= inst;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/forward_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module forward_unit (
	input cpu_pkg::id_ex_t id_ex,
	input cpu_pkg::ex_mem_t ex_mem,
	input cpu_pkg::mem_wb_t mem_wb,
	output cpu_pkg::fwd_sel_t fwd_a,
	output cpu_pkg::fwd_sel_t fwd_b,
	output cpu_pkg::fwd_sel_t fwd_store
);
	import cpu_pkg::*;

	logic b_is_reg;

	// The younger writer in MEM takes priority over WB
	function automatic fwd_sel_t pick(input logic [$clog2(`NREGS)-1:0] src);
		if (ex_mem.valid && ex_mem.regwrite && (ex_mem.rd != '0) && (ex_mem.rd == src))
			return FWD_MEM;
		if (mem_wb.valid && mem_wb.regwrite && (mem_wb.rd != '0) && (mem_wb.rd == src))
			return FWD_WB;
		return FWD_REG;
	endfunction

	assign b_is_reg = id_ex.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
		OP_BEQ, OP_BNE};

	assign fwd_a = pick(id_ex.rs1);
	assign fwd_b = b_is_reg ? pick(id_ex.rs2) : FWD_REG; // Immediate forms ignore rs2
	assign fwd_store = (id_ex.op == OP_SW) ? pick(id_ex.rs2) : FWD_REG;

endmodule

`default_nettype wire

// ==== src/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module memory_stage (
	input logic input_clk,
	input logic rst,
	input cpu_pkg::ex_mem_t ex_mem,
	output logic [`XLEN-1:0] mem_fwd,
	output cpu_pkg::mem_wb_t mem_wb,
	output logic halted
);
	import cpu_pkg::*;

	localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

	logic [`XLEN-1:0] dmem [`DMEM_DEPTH];
	logic [DMEM_AW-1:0] addr;
	logic [`XLEN-1:0] load_data;
	logic store_en;

	assign addr = ex_mem.alu_out[DMEM_AW-1:0];
	assign load_data = dmem[addr];
	assign store_en = ex_mem.valid && (ex_mem.op == OP_SW) && !halted; // Frozen stores stay inert
	assign mem_fwd = ex_mem.alu_out;

	always_ff @(posedge input_clk) begin
		if (rst) begin
			for (int i = 0; i < `DMEM_DEPTH; i++)
				dmem[i] <= '0;
		end else if (store_en) begin
			dmem[addr] <= ex_mem.store_data;
		end
	end

	always_ff @(posedge input_clk) begin
		if (rst) begin
			mem_wb.valid <= 1'b0;
			mem_wb.regwrite <= 1'b0;
			halted <= 1'b0;
		end else if (!halted) begin
			mem_wb.valid <= ex_mem.valid;
			mem_wb.op <= ex_mem.op;
			mem_wb.rd <= ex_mem.rd;
			mem_wb.wdata <= (ex_mem.op == OP_LW) ? load_data : ex_mem.alu_out;
			mem_wb.regwrite <= ex_mem.valid && ex_mem.regwrite;
			halted <= ex_mem.valid && (ex_mem.op == OP_HLT); // Sticky, only reset clears it
		end
	end

endmodule

`default_nettype wire

// ==== testbench/cpu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
	input logic input_clk,
	input logic rst,
	input logic retire_valid,
	input logic halted
);

	// Reset clears the strobe and the halt flag by the next edge
	reset_clears: assert property (@(posedge input_clk) rst |=> !retire_valid && !halted)
		else $error("retire_valid or halted still high after reset");

	halt_sticky: assert property (@(posedge input_clk) halted && !rst |=> halted)
		else $error("halted fell without reset");

	// A frozen core retires nothing
	quiet_when_halted: assert property (@(posedge input_clk) halted |-> !retire_valid)
		else $error("retire_valid high while halted");

endmodule

bind cpu5stage cpu_props i_props (
	.input_clk(input_clk),
	.rst(rst),
	.retire_valid(retire_valid),
	.halted(halted)
);

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module cpu_tb;
	import cpu_pkg::*;

	localparam int NTESTS = 5;
	localparam int PROG_MAX = 64;
	localparam int RESET_CYCLES = 8;
	localparam int HOLD_CYCLES = 10;
	localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

	logic clk;
	logic rst;
	logic imem_we;
	logic [IMEM_AW-1:0] imem_addr;
	logic [`XLEN-1:0] imem_wdata;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] cycles_consumed;
	logic retire_valid;
	retire_t retire;
	logic halted;

	logic [31:0] progs [NTESTS][PROG_MAX];
	int prog_len [NTESTS];
	string test_names [NTESTS];
	retire_t exp_q [$];
	int err_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	cpu5stage i_dut (
		.input_clk(clk),
		.rst(rst),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_wdata(imem_wdata),
		.PC(pc),
		.cycles_consumed(cycles_consumed),
		.retire_valid(retire_valid),
		.retire(retire),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic wait_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			err_count++;
		end
	endtask

	function automatic logic [31:0] enc_r(input opcode_t op, input int rd, input int rs1,
		input int rs2);
		return {op, rd[4:0], rs1[4:0], rs2[4:0], 11'd0};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_t op, input int rd, input int rs1,
		input int imm);
		return {op, rd[4:0], rs1[4:0], imm[15:0]};
	endfunction

	// Stores and branches put rs2 in the upper immediate bits
	function automatic logic [31:0] enc_s(input opcode_t op, input int rs1, input int rs2,
		input int off);
		return {op, 5'd0, rs1[4:0], rs2[4:0], off[10:0]};
	endfunction

	function automatic opcode_t random_alu_op();
		case ($urandom_range(0, 5))
			0: return OP_ADD;
			1: return OP_SUB;
			2: return OP_AND;
			3: return OP_OR;
			4: return OP_XOR;
			default: return OP_SLT;
		endcase
	endfunction

	function automatic int rand_reg();
		return $urandom_range(0, 7);
	endfunction

	task automatic emit(input int t, input logic [31:0] word);
		progs[t][prog_len[t]] = word;
		prog_len[t]++;
	endtask

	// The core fetches a few words past the halt, so those are NOPs
	task automatic finish_program(input int t);
		emit(t, enc_r(OP_HLT, 0, 0, 0));
		repeat (4) emit(t, 32'd0);
	endtask

	task automatic build_alu_chain(input int t);
		int last;
		int prev;
		int rd;
		opcode_t op;
		for (int r = 1; r <= 4; r++)
			emit(t, enc_i(OP_ADDI, r, 0, $urandom_range(0, 65535)));
		prev = 3;
		last = 4;
		for (int i = 0; i < 16; i++) begin
			rd = $urandom_range(1, 6);
			op = ($urandom_range(0, 6) == 0) ? OP_ADDI : random_alu_op();
			if (op == OP_ADDI)
				emit(t, enc_i(OP_ADDI, rd, last, $urandom_range(0, 65535)));
			else
				emit(t, enc_r(op, rd, last, prev)); // Sources are the last two results
			prev = last;
			last = rd;
		end
		finish_program(t);
	endtask

	task automatic build_load_store(input int t);
		emit(t, enc_i(OP_ADDI, 1, 0, $urandom_range(0, 200)));
		emit(t, enc_i(OP_ADDI, 2, 0, $urandom_range(0, 65535)));
		emit(t, enc_s(OP_SW, 1, 2, 0));
		emit(t, enc_i(OP_ADDI, 3, 2, 5));
		emit(t, enc_s(OP_SW, 1, 3, 1));
		emit(t, enc_i(OP_LW, 4, 1, 0));
		emit(t, enc_r(OP_ADD, 5, 4, 3));
		emit(t, enc_i(OP_LW, 6, 1, 1));
		emit(t, enc_s(OP_SW, 1, 6, 2)); // Loaded value used as store data
		emit(t, enc_i(OP_LW, 7, 1, 2));
		emit(t, enc_r(OP_ADD, 8, 7, 7));
		emit(t, enc_i(OP_LW, 9, 1, 5));
		emit(t, enc_r(OP_SUB, 10, 5, 9));
		for (int k = 0; k < 4; k++) begin
			emit(t, enc_i(OP_ADDI, 11, 0, $urandom_range(0, 65535)));
			emit(t, enc_s(OP_SW, 1, 11, 6 + k));
			emit(t, enc_i(OP_LW, 12, 1, 6 + k));
			emit(t, enc_r(OP_XOR, 13, 12, 13));
		end
		finish_program(t);
	endtask

	task automatic build_branches(input int t);
		emit(t, enc_i(OP_ADDI, 1, 0, 7));
		emit(t, enc_s(OP_BEQ, 1, 0, 2));
		emit(t, enc_i(OP_ADDI, 2, 0, 1));
		emit(t, enc_i(OP_ADDI, 3, 0, 2));
		emit(t, enc_s(OP_BNE, 1, 0, 2));
		emit(t, enc_i(OP_ADDI, 4, 0, 99));
		emit(t, enc_i(OP_ADDI, 5, 0, 98));
		emit(t, enc_i(OP_ADDI, 6, 1, 1));
		emit(t, enc_s(OP_BEQ, 7, 0, 1));
		emit(t, enc_i(OP_ADDI, 8, 0, 55));
		emit(t, enc_i(OP_JAL, 9, 0, 2));
		emit(t, enc_i(OP_ADDI, 10, 0, 1));
		emit(t, enc_i(OP_ADDI, 11, 0, 2));
		emit(t, enc_r(OP_ADD, 12, 9, 6));
		emit(t, enc_s(OP_BNE, 13, 0, 3));
		emit(t, enc_i(OP_ADDI, 14, 12, 3));
		emit(t, enc_s(OP_BEQ, 14, 0, 1));
		emit(t, enc_i(OP_JAL, 0, 0, 1));
		emit(t, enc_i(OP_ADDI, 15, 0, 77));
		emit(t, enc_i(OP_LW, 16, 0, 0));
		emit(t, enc_s(OP_BEQ, 16, 0, 1)); // Branch waits on the load
		emit(t, enc_i(OP_ADDI, 17, 0, 66));
		emit(t, enc_i(OP_ADDI, 18, 16, 4));
		emit(t, enc_s(OP_BNE, 18, 0, 0));
		emit(t, enc_r(OP_ADD, 19, 18, 9));
		finish_program(t);
	endtask

	task automatic build_r0(input int t);
		emit(t, enc_i(OP_ADDI, 0, 0, 5));
		emit(t, enc_r(OP_ADD, 1, 0, 0));
		emit(t, enc_i(OP_ADDI, 2, 0, 9));
		emit(t, enc_r(OP_ADD, 0, 2, 2));
		emit(t, enc_r(OP_ADD, 3, 0, 2));
		emit(t, enc_s(OP_SW, 0, 2, 3));
		emit(t, enc_i(OP_LW, 0, 0, 3));
		emit(t, enc_r(OP_ADD, 4, 0, 2));
		emit(t, enc_i(OP_JAL, 0, 0, 0));
		emit(t, enc_i(OP_ADDI, 5, 0, -1));
		emit(t, enc_r(OP_OR, 6, 0, 5));
		emit(t, enc_r(OP_SUB, 7, 0, 5));
		finish_program(t);
	endtask

	task automatic build_random(input int t);
		int kind;
		int off;
		for (int i = 0; i < 40; i++) begin
			kind = $urandom_range(0, 9);
			off = $urandom_range(0, 3);
			if (off > 39 - i)
				off = 39 - i; // Targets never pass the halt at word 40
			case (kind)
				0, 1, 2, 3: emit(t, enc_r(random_alu_op(), rand_reg(), rand_reg(), rand_reg()));
				4: emit(t, enc_i(OP_ADDI, rand_reg(), rand_reg(), $urandom_range(0, 65535)));
				5: emit(t, enc_i(OP_LW, rand_reg(), rand_reg(), $urandom_range(0, 15)));
				6: emit(t, enc_s(OP_SW, rand_reg(), rand_reg(), $urandom_range(0, 15)));
				7: emit(t, enc_s(OP_BEQ, rand_reg(), 0, off));
				8: emit(t, enc_s(OP_BNE, rand_reg(), 0, off));
				default: emit(t, enc_i(OP_JAL, rand_reg(), 0, off));
			endcase
		end
		finish_program(t);
	endtask

	// Architectural model that lists every register write in program order
	function automatic void iss_run(input int t, output logic [31:0] hlt_pc, output bit reached);
		logic [31:0] regs [`NREGS];
		logic [31:0] dmem [`DMEM_DEPTH];
		logic [31:0] cur_pc;
		logic [31:0] next_pc;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [4:0] rd;
		logic wr;
		for (int i = 0; i < `NREGS; i++)
			regs[i] = '0;
		for (int i = 0; i < `DMEM_DEPTH; i++)
			dmem[i] = '0;
		cur_pc = '0;
		hlt_pc = '0;
		reached = 1'b0;
		for (int step = 0; step < 4096; step++) begin
			if (cur_pc >= prog_len[t])
				return;
			inst = progs[t][int'(cur_pc)];
			rd = inst[25:21];
			a = regs[inst[20:16]];
			b = regs[inst[15:11]];
			imm = {{16{inst[15]}}, inst[15:0]};
			res = '0;
			wr = 1'b1;
			next_pc = cur_pc + 1;
			case (inst[31:26])
				OP_ADD: res = a + b;
				OP_SUB: res = a - b;
				OP_AND: res = a & b;
				OP_OR: res = a | b;
				OP_XOR: res = a ^ b;
				OP_SLT: res = {31'd0, $signed(a) < $signed(b)};
				OP_ADDI: res = a + imm;
				OP_LW: res = dmem[(a + imm) % `DMEM_DEPTH];
				OP_JAL: begin
					res = cur_pc + 1;
					next_pc = cur_pc + 1 + imm;
				end
				OP_HLT: begin
					hlt_pc = cur_pc;
					reached = 1'b1;
					return;
				end
				default: wr = 1'b0;
			endcase
			if (inst[31:26] == OP_SW)
				dmem[(a + imm) % `DMEM_DEPTH] = b;
			if ((inst[31:26] == OP_BEQ && a == b) || (inst[31:26] == OP_BNE && a != b))
				next_pc = cur_pc + 1 + imm;
			if (wr && rd != 5'd0) begin
				regs[rd] = res;
				exp_q.push_back(retire_t'{rd: rd, wdata: res});
			end
			cur_pc = next_pc;
		end
	endfunction

	always @(negedge clk) begin : compare_retire
		retire_t want;
		if (!rst && retire_valid) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected retirement of r%0d with value %h at %0t",
					retire.rd, retire.wdata, $time);
				err_count++;
			end else begin
				want = exp_q.pop_front();
				check_value("retire.rd", {27'd0, retire.rd}, {27'd0, want.rd});
				check_value("retire.wdata", retire.wdata, want.wdata);
			end
		end
	end

	initial begin : watchdog
		@(posedge clk);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the core did not halt within %0d cycles", cycle_count);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic run_test(input int t, output bit ok);
		int err_before;
		logic [31:0] hlt_pc;
		logic [31:0] pc_hold;
		logic [31:0] cyc_hold;
		bit reached;
		err_before = err_count;
		rst = 1'b1;
		for (int i = 0; i < prog_len[t]; i++) begin
			imem_we = 1'b1;
			imem_addr = IMEM_AW'(i);
			imem_wdata = progs[t][i];
			wait_cycle();
		end
		imem_we = 1'b0;
		repeat (RESET_CYCLES) wait_cycle();
		check_value("PC", pc, 32'd0);
		check_value("cycles_consumed", cycles_consumed, 32'd0);
		check_value("retire_valid", {31'd0, retire_valid}, 32'd0);
		check_value("halted", {31'd0, halted}, 32'd0);
		exp_q.delete();
		iss_run(t, hlt_pc, reached);
		if (!reached) begin
			$display("Reference model never reached a halt in program %0d", t);
			err_count++;
			ok = 1'b0;
			return;
		end
		rst = 1'b0;
		while (!halted)
			wait_cycle();
		pc_hold = pc;
		cyc_hold = cycles_consumed;
		repeat (HOLD_CYCLES) begin
			wait_cycle();
			check_value("PC", pc, pc_hold);
			check_value("cycles_consumed", cycles_consumed, cyc_hold);
			check_value("halted", {31'd0, halted}, 32'd1);
		end
		check_value("PC", pc, hlt_pc + 4); // Fetch runs three words past the halt
		if (exp_q.size() != 0) begin
			$display("Test %0d: %0d expected register writes never retired", t, exp_q.size());
			err_count++;
		end
		rst = 1'b1;
		ok = (err_count == err_before);
		$display("Test %0d %s: %s, %0d errors", t, test_names[t], ok ? "passed" : "failed",
			err_count - err_before);
	endtask

	initial begin : main
		int passed;
		bit ok;
		rst = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		passed = 0;
		void'($urandom(32'he3e0a714));
		test_names = '{"alu_chain", "load_store", "branch_jump", "r0_writes", "random_mix"};
		for (int t = 0; t < NTESTS; t++)
			prog_len[t] = 0;
		build_alu_chain(0);
		build_load_store(1);
		build_branches(2);
		build_r0(3);
		build_random(4);
		for (int t = 0; t < NTESTS; t++)
			cycle_limit += 4 * prog_len[t] + 20 + prog_len[t] + RESET_CYCLES;
		for (int t = 0; t < NTESTS; t++) begin
			run_test(t, ok);
			if (ok)
				passed++;
		end
		$display("%0d of %0d tests passed, %0d errors", passed, NTESTS, err_count);
		if (err_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
